// ==== axi_pkg.sv ====
package axi_pkg;

    // fixed burst settings for the instruction refill.
    localparam logic [1:0] burst_incr      = 2'b01;
    localparam logic [2:0] size_word       = 3'b010;  // four bytes per beat.
    localparam int         beats_per_block = 4;
    localparam logic [3:0] fetch_id        = 4'd0;

    // read address channel, driven by the master.
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    // read data channel, driven by the slave.
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

endpackage

// ==== core_pkg.sv ====
package core_pkg;

    localparam int addr_width   = 32;
    localparam int block_bytes  = 16;
    localparam int cache_blocks = 2;

    // derived cache geometry.
    localparam int block_words = block_bytes / 4;
    localparam int word_bits   = $clog2(block_words);
    localparam int offset_bits = $clog2(block_bytes);
    localparam int index_bits  = $clog2(cache_blocks);
    localparam int tag_bits    = addr_width - offset_bits - index_bits;

    localparam logic [addr_width-1:0] reset_pc = 32'h3000_0000;

    // rv32i major opcodes.
    localparam logic [6:0] opc_reg    = 7'b0110011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_system = 7'b1110011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word seen through each encoding format.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } inst_t;

    typedef enum logic [3:0] {
        op_reg, op_imm, op_load, op_store, op_branch, op_lui,
        op_auipc, op_jal, op_jalr, op_system, op_illegal
    } op_class_e;

    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] addr;
    } lookup_req_t;

    typedef struct packed {
        logic  valid;
        inst_t inst;
    } lookup_resp_t;

    typedef struct packed {
        logic [addr_width-1:0] pc;
        inst_t                 inst;
    } fetch_packet_t;

    typedef struct packed {
        logic [addr_width-1:0] pc;
        op_class_e             op_class;
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [2:0]            funct3;
        logic [31:0]           imm;
    } decoded_t;

endpackage

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            redirect,
    input  logic [core_pkg::addr_width-1:0] redirect_pc,
    output core_pkg::lookup_req_t           req,
    input  core_pkg::lookup_resp_t          resp,
    output core_pkg::fetch_packet_t         packet,
    output logic                            packet_valid,
    input  logic                            packet_ready
);

    logic [core_pkg::addr_width-1:0] pc;  // address of the next word to deliver.
    logic                            pending;
    logic                            stale;
    logic                            slot_free;
    logic                            take_resp;

    // the output register can accept a word when empty or draining this cycle.
    assign slot_free = !packet_valid || packet_ready;

    assign req.valid = !pending && slot_free && !redirect;
    assign req.addr  = pc;

    // an answer to a lookup issued before a redirect is thrown away.
    assign take_resp = resp.valid && !stale && !redirect;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc           <= core_pkg::reset_pc;
            pending      <= 1'b0;
            stale        <= 1'b0;
            packet_valid <= 1'b0;
        end else begin
            if (resp.valid) begin
                pending <= 1'b0;
            end else if (req.valid) begin
                pending <= 1'b1;
            end

            if (resp.valid) begin
                stale <= 1'b0;
            end else if (redirect && pending) begin
                stale <= 1'b1;  // the refill keeps going, only the answer is lost.
            end

            if (redirect) begin
                pc <= redirect_pc;
            end else if (take_resp) begin
                pc <= pc + 32'd4;
            end

            if (redirect) begin
                packet_valid <= 1'b0;
            end else if (take_resp) begin
                packet_valid <= 1'b1;
            end else if (packet_ready) begin
                packet_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take_resp) begin
            packet.pc   <= pc;
            packet.inst <= resp.inst;
        end
    end

endmodule

// ==== icache.sv ====
`timescale 1ns/1ps

module icache (
    input  logic                   clock,
    input  logic                   arst_n,
    input  core_pkg::lookup_req_t  req,
    output core_pkg::lookup_resp_t resp,
    output axi_pkg::axi_ar_t       ar,
    input  logic                   arready,
    input  axi_pkg::axi_r_t        r,
    output logic                   rready
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } state_e;

    state_e                          state;
    logic                            lk_valid;
    logic [core_pkg::addr_width-1:0] lk_addr;
    logic [core_pkg::index_bits-1:0] lk_index;
    logic [core_pkg::word_bits-1:0]  lk_word;
    logic [core_pkg::tag_bits-1:0]   lk_tag;
    logic [core_pkg::word_bits-1:0]  beat;
    logic                            hit;

    logic [core_pkg::cache_blocks-1:0] block_valid;
    logic [core_pkg::tag_bits-1:0]     tags [core_pkg::cache_blocks];
    logic [31:0]                       data [core_pkg::cache_blocks][core_pkg::block_words];

    // split the held lookup address into tag, index and word select.
    assign lk_index = lk_addr[core_pkg::offset_bits +: core_pkg::index_bits];
    assign lk_word  = lk_addr[2 +: core_pkg::word_bits];
    assign lk_tag   = lk_addr[core_pkg::addr_width-1 -: core_pkg::tag_bits];

    assign hit = block_valid[lk_index] && (tags[lk_index] == lk_tag);

    assign resp.valid = lk_valid && hit;
    assign resp.inst  = data[lk_index][lk_word];

    always_comb begin
        ar.valid = (state == st_addr);
        ar.addr  = {lk_addr[core_pkg::addr_width-1:core_pkg::offset_bits],
                    {core_pkg::offset_bits{1'b0}}};  // whole aligned block.
        ar.id    = axi_pkg::fetch_id;
        ar.len   = 8'(axi_pkg::beats_per_block - 1);
        ar.size  = axi_pkg::size_word;
        ar.burst = axi_pkg::burst_incr;
    end

    assign rready = (state == st_data);

    always_ff @(posedge clock) begin
        if (req.valid) begin
            lk_addr <= req.addr;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            lk_valid    <= 1'b0;
            block_valid <= '0;
            beat        <= '0;
        end else begin
            lk_valid <= req.valid;
            case (state)
                st_idle: begin
                    if (lk_valid && !hit) begin
                        block_valid[lk_index] <= 1'b0;
                        state                 <= st_addr;
                    end
                end
                st_addr: begin
                    if (arready) begin
                        beat  <= '0;
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (r.valid) begin
                        beat <= beat + 1'b1;
                        if (r.last) begin
                            block_valid[lk_index] <= 1'b1;
                            // look the same address up again, which now hits.
                            lk_valid              <= 1'b1;
                            state                 <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // beats land in block order, the tag goes in with the last one.
    always_ff @(posedge clock) begin
        if (state == st_data && r.valid) begin
            data[lk_index][beat] <= r.data;
            if (r.last) begin
                tags[lk_index] <= lk_tag;
            end
        end
    end

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  core_pkg::fetch_packet_t packet,
    output core_pkg::decoded_t      decoded
);

    core_pkg::inst_t  inst;
    core_pkg::i_fmt_t i_view;
    core_pkg::s_fmt_t s_view;
    core_pkg::u_fmt_t u_view;

    assign inst   = packet.inst;
    assign i_view = inst.i_fmt;
    assign s_view = inst.s_fmt;
    assign u_view = inst.u_fmt;

    always_comb begin
        decoded.pc       = packet.pc;
        decoded.rd       = inst.r_fmt.rd;  // register fields sit in the same place always.
        decoded.rs1      = inst.r_fmt.rs1;
        decoded.rs2      = inst.r_fmt.rs2;
        decoded.funct3   = inst.r_fmt.funct3;
        decoded.op_class = core_pkg::op_illegal;
        decoded.imm      = '0;

        case (inst.r_fmt.opcode)
            core_pkg::opc_reg: begin
                decoded.op_class = core_pkg::op_reg;
            end
            core_pkg::opc_imm, core_pkg::opc_load, core_pkg::opc_jalr, core_pkg::opc_system: begin
                case (inst.r_fmt.opcode)
                    core_pkg::opc_imm:  decoded.op_class = core_pkg::op_imm;
                    core_pkg::opc_load: decoded.op_class = core_pkg::op_load;
                    core_pkg::opc_jalr: decoded.op_class = core_pkg::op_jalr;
                    default:            decoded.op_class = core_pkg::op_system;
                endcase
                decoded.imm = {{20{i_view.imm[11]}}, i_view.imm};
            end
            core_pkg::opc_store: begin
                decoded.op_class = core_pkg::op_store;
                decoded.imm      = {{20{s_view.imm_hi[6]}}, s_view.imm_hi, s_view.imm_lo};
            end
            core_pkg::opc_branch: begin
                decoded.op_class = core_pkg::op_branch;
                // b-type scatters the offset over the two s-type immediate fields.
                decoded.imm      = {{20{s_view.imm_hi[6]}}, s_view.imm_lo[0],
                                    s_view.imm_hi[5:0], s_view.imm_lo[4:1], 1'b0};
            end
            core_pkg::opc_lui, core_pkg::opc_auipc: begin
                decoded.op_class = (inst.r_fmt.opcode == core_pkg::opc_lui) ?
                                   core_pkg::op_lui : core_pkg::op_auipc;
                decoded.imm      = {u_view.imm, 12'b0};
            end
            core_pkg::opc_jal: begin
                decoded.op_class = core_pkg::op_jal;
                decoded.imm      = {{12{u_view.imm[19]}}, u_view.imm[7:0], u_view.imm[8],
                                    u_view.imm[18:9], 1'b0};
            end
            default: begin
                decoded.op_class = core_pkg::op_illegal;
            end
        endcase
    end

endmodule

// ==== fetch_core.sv ====
`timescale 1ns/1ps

module fetch_core (
    input  logic                            clock,
    input  logic                            arst_n,
    output axi_pkg::axi_ar_t                ar,
    input  logic                            arready,
    input  axi_pkg::axi_r_t                 r,
    output logic                            rready,
    input  logic                            redirect,
    input  logic [core_pkg::addr_width-1:0] redirect_pc,
    output core_pkg::decoded_t              out,
    output logic                            out_valid,
    input  logic                            out_ready
);

    core_pkg::lookup_req_t   req;
    core_pkg::lookup_resp_t  resp;
    core_pkg::fetch_packet_t packet;

    fetch_unit fetch_unit_i (
        .clock        (clock      ),
        .arst_n       (arst_n     ),
        .redirect     (redirect   ),
        .redirect_pc  (redirect_pc),
        .req          (req        ),
        .resp         (resp       ),
        .packet       (packet     ),
        .packet_valid (out_valid  ),
        .packet_ready (out_ready  )
    );

    icache icache_i (
        .clock   (clock  ),
        .arst_n  (arst_n ),
        .req     (req    ),
        .resp    (resp   ),
        .ar      (ar     ),
        .arready (arready),
        .r       (r      ),
        .rready  (rready )
    );

    // decode straight off the fetch output register.
    inst_decoder inst_decoder_i (
        .packet  (packet),
        .decoded (out   )
    );

endmodule

// ==== fetch_core_assertions.sv ====
`timescale 1ns/1ps

module fetch_core_assertions (
    input logic               clock,
    input logic               arst_n,
    input axi_pkg::axi_ar_t   ar,
    input logic               arready,
    input logic               rready,
    input logic               redirect,
    input core_pkg::decoded_t out,
    input logic               out_valid,
    input logic               out_ready
);

    int failures = 0;  // the testbench reads this at the end of the run.

    ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
        ar.valid && !arready |=> ar.valid && $stable(ar))
        else begin
            $error("ar dropped or changed before arready");
            failures = failures + 1;
        end

    // one burst shape for every refill.
    ar_fixed: assert property (@(posedge clock) disable iff (!arst_n)
        ar.valid |-> ar.len == 8'(axi_pkg::beats_per_block - 1) &&
                     ar.size == axi_pkg::size_word && ar.burst == axi_pkg::burst_incr &&
                     ar.id == axi_pkg::fetch_id)
        else begin
            $error("ar burst fields differ from a block refill");
            failures = failures + 1;
        end

    out_hold: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid && !out_ready && !redirect |=> out_valid && $stable(out))
        else begin
            $error("out changed while stalled");
            failures = failures + 1;
        end

    reset_quiet: assert property (@(posedge clock)
        !arst_n |-> !ar.valid && !rready && !out_valid)
        else begin
            $error("handshake strobes high during reset");
            failures = failures + 1;
        end

endmodule

bind fetch_core fetch_core_assertions fetch_core_assertions_i (
    .clock     (clock    ),
    .arst_n    (arst_n   ),
    .ar        (ar       ),
    .arready   (arready  ),
    .rready    (rready   ),
    .redirect  (redirect ),
    .out       (out      ),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

// ==== fetch_core_tb.sv ====
`timescale 1ns/1ps

module fetch_core_tb;

    localparam int  n_insts     = 2000;
    localparam int  mem_words   = 64;
    localparam real watchdog_ns = real'(n_insts) * 60.0 * 20.0;

    logic               clock = 1'b0;
    logic               arst_n = 1'b0;
    axi_pkg::axi_ar_t   ar;
    logic               arready = 1'b0;
    axi_pkg::axi_r_t    r = '0;
    logic               rready;
    logic               redirect = 1'b0;
    logic [31:0]        redirect_pc = '0;
    core_pkg::decoded_t out;
    logic               out_valid;
    logic               out_ready = 1'b0;

    integer      seed = 32'h3b38_634a;
    logic [31:0] mem [mem_words];  // repeats every 256 bytes.

    logic [31:0] exp_pc = core_pkg::reset_pc;
    logic        model_valid [core_pkg::cache_blocks] = '{default: 1'b0};
    logic [31:0] model_tag [core_pkg::cache_blocks];
    logic        burst_seen = 1'b0;  // a refill was read for the lookup of exp_pc.
    logic        prev_valid = 1'b0;
    int          accepted = 0;
    int          misses = 0;
    int          bursts = 0;
    int          beats = 0;

    logic        burst_active = 1'b0;
    logic [31:0] burst_addr = '0;
    logic [7:0]  burst_len = '0;  // the slave ends the burst after len + 1 beats.
    int          beat_idx = 0;

    fetch_core fetch_core_i (
        .clock       (clock      ),
        .arst_n      (arst_n     ),
        .ar          (ar         ),
        .arready     (arready    ),
        .r           (r          ),
        .rready      (rready     ),
        .redirect    (redirect   ),
        .redirect_pc (redirect_pc),
        .out         (out        ),
        .out_valid   (out_valid  ),
        .out_ready   (out_ready  )
    );

    always #10 clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "test stopped");
    endtask

    function automatic logic [6:0] opcode_at(input int k);
        case (k)
            0:       return 7'b0110011;
            1:       return 7'b0010011;
            2:       return 7'b0000011;
            3:       return 7'b0100011;
            4:       return 7'b1100011;
            5:       return 7'b0110111;
            6:       return 7'b0010111;
            7:       return 7'b1101111;
            8:       return 7'b1100111;
            9:       return 7'b1110011;
            10:      return 7'b0001111;  // fence has no class here.
            11:      return 7'b0000000;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic core_pkg::op_class_e expected_class(input logic [31:0] w);
        case (w[6:0])
            7'b0110011: return core_pkg::op_reg;
            7'b0010011: return core_pkg::op_imm;
            7'b0000011: return core_pkg::op_load;
            7'b0100011: return core_pkg::op_store;
            7'b1100011: return core_pkg::op_branch;
            7'b0110111: return core_pkg::op_lui;
            7'b0010111: return core_pkg::op_auipc;
            7'b1101111: return core_pkg::op_jal;
            7'b1100111: return core_pkg::op_jalr;
            7'b1110011: return core_pkg::op_system;
            default:    return core_pkg::op_illegal;
        endcase
    endfunction

    // rv32i immediates taken straight from the instruction bit positions.
    function automatic logic [31:0] expected_imm(input logic [31:0] w);
        case (w[6:0])
            7'b0010011, 7'b0000011, 7'b1100111, 7'b1110011:
                return {{20{w[31]}}, w[31:20]};
            7'b0100011: return {{20{w[31]}}, w[31:25], w[11:7]};
            7'b1100011: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            7'b0110111, 7'b0010111: return {w[31:12], 12'h000};
            7'b1101111: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:    return 32'h0;
        endcase
    endfunction

    function automatic logic model_hit(input logic [31:0] addr);
        int idx;
        idx = int'((addr / core_pkg::block_bytes) % core_pkg::cache_blocks);
        return model_valid[idx] &&
               model_tag[idx] == addr / (core_pkg::block_bytes * core_pkg::cache_blocks);
    endfunction

    function automatic void model_fill(input logic [31:0] addr);
        int idx;
        idx = int'((addr / core_pkg::block_bytes) % core_pkg::cache_blocks);
        model_valid[idx] = 1'b1;
        model_tag[idx]   = addr / (core_pkg::block_bytes * core_pkg::cache_blocks);
    endfunction

    task automatic fill_memory();
        logic [31:0] word;
        for (int i = 0; i < mem_words; i++) begin
            word      = $random(seed);
            word[6:0] = opcode_at($unsigned($random(seed)) % 13);
            mem[i]    = word;
        end
    endtask

    task automatic watch_cycle();
        logic [31:0] word;
        word = mem[exp_pc[7:2]];
        if (ar.valid && arready) begin
            if (burst_seen || model_hit(exp_pc)) begin
                stop_with_error("a refill burst was read for a lookup the model counts as a hit");
            end
            check_value("ar.addr", ar.addr, {exp_pc[31:4], 4'h0});
            burst_seen = 1'b1;
            bursts     = bursts + 1;
        end
        if (r.valid && rready) begin
            beats = beats + 1;
            if (r.last) begin
                check_value("beats in burst", 32'(beats), 32'(axi_pkg::beats_per_block));
                beats = 0;
            end
        end
        // a new word in the output register ends one lookup of the stream.
        if (out_valid && !prev_valid) begin
            check_value("out.pc", out.pc, exp_pc);
            if (!model_hit(exp_pc)) begin
                if (!burst_seen) begin
                    stop_with_error("the model expected a cache miss but no burst was read");
                end
                misses = misses + 1;
                model_fill(exp_pc);
            end
            burst_seen = 1'b0;
        end
        if (out_valid && out_ready && !redirect) begin
            check_value("out.pc", out.pc, exp_pc);
            check_value("out.op_class", 32'(out.op_class), 32'(expected_class(word)));
            check_value("out.rd", 32'(out.rd), 32'(word[11:7]));
            check_value("out.rs1", 32'(out.rs1), 32'(word[19:15]));
            check_value("out.rs2", 32'(out.rs2), 32'(word[24:20]));
            check_value("out.funct3", 32'(out.funct3), 32'(word[14:12]));
            check_value("out.imm", out.imm, expected_imm(word));
            accepted = accepted + 1;
            exp_pc   = exp_pc + 32'd4;
        end
        if (redirect) begin
            exp_pc = redirect_pc;
        end
        prev_valid = out_valid;
    endtask

    task automatic drive_slave();
        logic [31:0] rnd;
        rnd = $random(seed);
        if (ar.valid && arready) begin
            burst_active = 1'b1;
            burst_addr   = ar.addr;
            burst_len    = ar.len;
            beat_idx     = 0;
        end
        if (r.valid && rready) begin
            beat_idx = beat_idx + 1;
            if (r.last) begin
                burst_active = 1'b0;
            end
        end
        arready <= !burst_active && rnd[1:0] == 2'b00;
        if (!r.valid || rready) begin
            if (burst_active && rnd[2]) begin
                r.valid <= 1'b1;
                r.data  <= mem[burst_addr[7:2] + 6'(beat_idx)];
                r.last  <= beat_idx == int'(burst_len);
                r.resp  <= 2'b00;
                r.id    <= axi_pkg::fetch_id;
            end else begin
                r.valid <= 1'b0;
            end
        end
    endtask

    task automatic drive_core();
        logic [31:0] rnd;
        rnd = $random(seed);
        out_ready <= rnd[0];
        // redirect only while a word is held, so no lookup is in flight.
        if (out_valid && !out_ready && !redirect && rnd[4:1] == 4'h0) begin
            redirect    <= 1'b1;
            redirect_pc <= core_pkg::reset_pc + {24'h0, rnd[10:5], 2'b00};
        end else begin
            redirect <= 1'b0;
        end
    endtask

    always @(posedge clock) begin
        if (arst_n) begin
            watch_cycle();
            drive_slave();
            drive_core();
        end
    end

    always @(posedge clock) begin
        if (fetch_core_i.fetch_core_assertions_i.failures != 0) begin
            stop_with_error("a protocol assertion failed");
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: %0d instructions were not delivered in time", n_insts);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin
        fill_memory();
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;
        wait (accepted == n_insts);
        check_value("burst count", 32'(bursts), 32'(misses));
        if (fetch_core_i.fetch_core_assertions_i.failures != 0) begin
            $display("protocol assertions failed %0d times",
                     fetch_core_i.fetch_core_assertions_i.failures);
            $display("FAIL: see errors above");
            $fatal(1, "protocol assertion failures");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
axi_pkg.sv
core_pkg.sv
fetch_unit.sv
icache.sv
inst_decoder.sv
fetch_core.sv
fetch_core_assertions.sv
fetch_core_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --assert --timing -j 0
TOP      = fetch_core_tb
FILELIST = filelist.f
BUILD    = obj_dir
RUNFLAGS = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run $(TOP) with $(SIM)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNFLAGS)

clean:
	rm -rf $(BUILD)
